// ==== hw/rv_frontend_pkg.sv ====
// shared types and constants for the rv_frontend fetch path, imported by every rtl module
package rv_frontend_pkg;

    localparam int FETCH_DEPTH = 4;  // default buffer capacity in words

    typedef logic [31:0] xlen_t;  // address or raw instruction word

    typedef struct packed {
        xlen_t addr;  // word aligned read address
    } mem_req_t;

    typedef struct packed {
        xlen_t data;   // read data
        logic  error;  // bus error on this read
    } mem_resp_t;

    typedef struct packed {
        xlen_t data;        // fetched word
        xlen_t addr;        // word address, raw target pc on a misaligned record
        logic  hw_off;      // skip the low halfword
        logic  bus_err;     // memory reported an error
        logic  misaligned;  // redirect target failed the alignment check
    } fetch_word_t;

    typedef struct packed {
        xlen_t bits;        // upper half zero when compressed
        xlen_t addr;        // address of first halfword
        logic  compressed;
        logic  fault;       // needed a word that came back with a bus error
        logic  misaligned;
    } insn_t;

    typedef enum logic [3:0] {
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_op,
        cls_op_imm,
        cls_lui,
        cls_auipc,
        cls_system,
        cls_misc_mem,
        cls_compressed,
        cls_illegal
    } opclass_e;

    typedef struct packed {
        insn_t    insn;
        opclass_e opclass;
    } decoded_t;

    // ring index step, wraps to zero at depth
    function automatic int unsigned ring_next(input int unsigned ptr, input int unsigned depth);
        return (ptr + 1 >= depth) ? 0 : ptr + 1;
    endfunction

endpackage

// ==== hw/fetch_unit.sv ====
// fetch producer, follows the pc from a redirect and issues word reads under buffer credits
`timescale 1ns/10ps

module fetch_unit
    import rv_frontend_pkg::*;
#(
    parameter int RVC_ENABLED = 0,
    parameter int DEPTH       = FETCH_DEPTH
) (
    input  logic                         CLK,
    input  logic                         rst_n,
    input  logic                         redirect,
    input  xlen_t                        redirect_pc,
    input  logic                         mem_req_ready,
    input  logic                         mem_resp_valid,
    input  mem_resp_t                    mem_resp,
    input  logic [$clog2(DEPTH + 1)-1:0] free_words,
    output logic                         mem_req_valid,
    output mem_req_t                     mem_req,
    output logic                         word_valid,
    output fetch_word_t                  word
);

    localparam int CW = $clog2(DEPTH + 1);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef enum logic [1:0] {
        st_idle,
        st_fetching,
        st_halted
    } state_e;

    state_e        state;
    xlen_t         next_pc;          // next fetch pc, bit 1 marks an upper-half start
    logic          mis_pend;         // misaligned record goes out this cycle
    logic [CW-1:0] outstanding;      // accepted reads not yet answered
    logic [CW-1:0] outstanding_nxt;
    logic [CW-1:0] stale;            // answers still owed to a flushed stream
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [29:0]   pend_word [DEPTH];  // in-flight word addresses
    logic          pend_off [DEPTH];   // matching halfword start
    logic          req_fire;
    logic          live_resp;
    logic          target_mis;

    assign target_mis = (RVC_ENABLED != 0) ? redirect_pc[0] : (redirect_pc[1:0] != 2'b00);

    assign mem_req_valid   = (state == st_fetching) && (outstanding < free_words);  // credit gate
    assign mem_req.addr    = {next_pc[31:2], 2'b00};
    assign req_fire        = mem_req_valid && mem_req_ready;
    assign live_resp       = mem_resp_valid && (stale == '0);  // in order, stale ones come first
    assign outstanding_nxt = outstanding + CW'(req_fire) - CW'(mem_resp_valid);

    always_comb begin
        word_valid = mis_pend || live_resp;
        if (mis_pend) begin
            word = '{data: '0, addr: next_pc, hw_off: 1'b0, bus_err: 1'b0, misaligned: 1'b1};
        end else begin
            word.data       = mem_resp.data;  // pass-through, same cycle
            word.addr       = {pend_word[rd_ptr], 2'b00};
            word.hw_off     = pend_off[rd_ptr];
            word.bus_err    = mem_resp.error;
            word.misaligned = 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state       <= st_idle;  // nothing fetched before the first redirect
            mis_pend    <= 1'b0;
            outstanding <= '0;
            stale       <= '0;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
        end else begin
            outstanding <= outstanding_nxt;
            mis_pend    <= 1'b0;
            if (redirect) begin
                stale    <= outstanding_nxt;  // all reads still out belong to the old stream
                wr_ptr   <= '0;
                rd_ptr   <= '0;
                next_pc  <= redirect_pc;
                mis_pend <= target_mis;
                state    <= target_mis ? st_idle : st_fetching;  // bad target, no reads
            end else begin
                if (mem_resp_valid && (stale != '0)) begin
                    stale <= stale - 1'b1;  // drop it
                end
                if (req_fire) begin
                    wr_ptr  <= PW'(ring_next(wr_ptr, DEPTH));
                    next_pc <= {next_pc[31:2] + 30'd1, 2'b00};  // aligned from here on
                end
                if (live_resp) begin
                    rd_ptr <= PW'(ring_next(rd_ptr, DEPTH));
                    if (mem_resp.error) begin
                        state <= st_halted;  // stop issuing after a bus error
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (req_fire) begin
            pend_word[wr_ptr] <= next_pc[31:2];
            pend_off[wr_ptr]  <= next_pc[1];  // only the first read after a redirect
        end
    end

endmodule

// ==== hw/fetch_buffer.sv ====
// fetch buffer, queues fetched words and cuts whole instructions out of the halfword stream
`timescale 1ns/10ps

module fetch_buffer
    import rv_frontend_pkg::*;
#(
    parameter int RVC_ENABLED = 0,
    parameter int DEPTH       = FETCH_DEPTH
) (
    input  logic                         CLK,
    input  logic                         rst_n,
    input  logic                         redirect,
    input  logic                         word_valid,
    input  fetch_word_t                  word,
    input  logic                         insn_ready,
    output logic [$clog2(DEPTH + 1)-1:0] free_words,
    output logic                         insn_valid,
    output insn_t                        insn
);

    localparam int CW = $clog2(DEPTH + 1);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    fetch_word_t   slots [DEPTH];  // word storage
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_next;
    logic [PW-1:0] wr_next;
    logic [CW-1:0] count;          // words held
    logic          rd_hw;          // halfword select in the head word
    logic          halted;         // fault sent, wait for redirect

    fetch_word_t   head;
    fetch_word_t   second;
    logic [15:0]   lo_hw;          // first halfword of the candidate
    logic          is_comp;
    logic          flagged;
    logic          spans;          // 32-bit insn crossing into the next word
    logic          have;
    logic [1:0]    adv;            // halfwords consumed on transfer
    logic [1:0]    hw_sum;
    logic          push;
    logic          fire;

    assign rd_next = PW'(ring_next(rd_ptr, DEPTH));
    assign wr_next = PW'(ring_next(wr_ptr, DEPTH));
    assign head    = slots[rd_ptr];
    assign second  = slots[rd_next];

    assign lo_hw   = rd_hw ? head.data[31:16] : head.data[15:0];
    assign is_comp = (RVC_ENABLED != 0) && (lo_hw[1:0] != 2'b11);  // rvc quadrants 0..2
    assign flagged = head.bus_err || head.misaligned;
    assign spans   = !flagged && !is_comp && rd_hw;
    assign have    = (count != '0) && (!spans || (count > CW'(1)));  // wait for the upper half

    assign insn_valid = !halted && have;
    assign fire       = insn_valid && insn_ready;
    assign push       = word_valid && !halted;  // words after a fault are dropped
    assign free_words = CW'(DEPTH) - count;
    assign hw_sum     = {1'b0, rd_hw} + adv;

    always_comb begin
        insn.addr       = head.addr | {30'd0, rd_hw, 1'b0};
        insn.compressed = 1'b0;
        insn.fault      = 1'b0;
        insn.misaligned = head.misaligned;
        if (flagged) begin
            insn.bits  = '0;  // fault record at the head address
            insn.fault = head.bus_err;
            adv        = 2'd0;
        end else if (is_comp) begin
            insn.bits       = {16'd0, lo_hw};
            insn.compressed = 1'b1;
            adv             = 2'd1;
        end else if (spans) begin
            insn.fault = second.bus_err;  // upper half lives in an error word
            insn.bits  = second.bus_err ? '0 : {second.data[15:0], lo_hw};
            adv        = 2'd2;
        end else begin
            insn.bits = head.data;  // aligned full word
            adv       = 2'd2;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n || redirect) begin
            count  <= '0;  // flush drops all buffered data
            rd_ptr <= '0;
            wr_ptr <= '0;
            rd_hw  <= 1'b0;
            halted <= 1'b0;
        end else begin
            count <= count + CW'(push) - CW'(fire && hw_sum[1]);
            if (push) begin
                wr_ptr <= wr_next;
                if (count == '0) begin
                    rd_hw <= word.hw_off;  // redirect to addr+2 skips the low half
                end
            end
            if (fire) begin
                rd_hw <= hw_sum[0];
                if (hw_sum[1]) begin
                    rd_ptr <= rd_next;  // head word used up
                end
                if (insn.fault || insn.misaligned) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            slots[wr_ptr] <= word;
        end
    end

endmodule

// ==== hw/insn_predecode.sv ====
// predecode stage, registers each instruction and tags it with its major opcode class
`timescale 1ns/10ps

module insn_predecode
    import rv_frontend_pkg::*;
(
    input  logic     CLK,
    input  logic     rst_n,
    input  logic     redirect,
    input  logic     insn_valid,
    input  insn_t    insn,
    input  logic     out_ready,
    output logic     insn_ready,
    output logic     out_valid,
    output decoded_t out
);

    // rv32 major opcodes, bits 6:0
    typedef enum logic [6:0] {
        opc_load     = 7'b0000011,
        opc_misc_mem = 7'b0001111,
        opc_op_imm   = 7'b0010011,
        opc_auipc    = 7'b0010111,
        opc_store    = 7'b0100011,
        opc_op       = 7'b0110011,
        opc_lui      = 7'b0110111,
        opc_branch   = 7'b1100011,
        opc_jalr     = 7'b1100111,
        opc_jal      = 7'b1101111,
        opc_system   = 7'b1110011
    } opcode_e;

    opcode_e  opcode;
    opclass_e cls;

    assign opcode     = opcode_e'(insn.bits[6:0]);
    assign insn_ready = !out_valid || out_ready;  // empty or draining

    always_comb begin
        case (opcode)
            opc_load:     cls = cls_load;
            opc_store:    cls = cls_store;
            opc_branch:   cls = cls_branch;
            opc_jal:      cls = cls_jal;
            opc_jalr:     cls = cls_jalr;
            opc_op:       cls = cls_op;
            opc_op_imm:   cls = cls_op_imm;
            opc_lui:      cls = cls_lui;
            opc_auipc:    cls = cls_auipc;
            opc_system:   cls = cls_system;
            opc_misc_mem: cls = cls_misc_mem;
            default:      cls = cls_illegal;  // unknown major opcode
        endcase
        if (insn.fault || insn.misaligned) begin
            cls = cls_illegal;
        end else if (insn.compressed) begin
            cls = cls_compressed;  // no expansion here
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (redirect) begin
            out_valid <= 1'b0;  // drop the held entry
        end else if (insn_ready) begin
            out_valid <= insn_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (insn_ready && insn_valid) begin
            out <= '{insn: insn, opclass: cls};
        end
    end

endmodule

// ==== hw/frontend_top.sv ====
// top level of the fetch front end, connects fetch unit, fetch buffer and predecode
`timescale 1ns/10ps

module frontend_top
    import rv_frontend_pkg::*;
#(
    parameter int RVC_ENABLED = 0,
    parameter int DEPTH       = FETCH_DEPTH
) (
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      redirect,
    input  xlen_t     redirect_pc,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    output mem_req_t  mem_req,
    input  logic      mem_resp_valid,
    input  mem_resp_t mem_resp,
    output logic      out_valid,
    input  logic      out_ready,
    output decoded_t  out
);

    logic [$clog2(DEPTH + 1)-1:0] free_words;  // credits back to the fetch unit
    logic                         word_valid;
    fetch_word_t                  word;
    logic                         insn_valid;
    logic                         insn_ready;
    insn_t                        insn;

    fetch_unit #(
        .RVC_ENABLED (RVC_ENABLED),
        .DEPTH       (DEPTH)
    ) u_fetch_unit (
        .CLK,
        .rst_n,
        .redirect,
        .redirect_pc,
        .mem_req_ready,
        .mem_resp_valid,
        .mem_resp,
        .free_words,
        .mem_req_valid,
        .mem_req,
        .word_valid,
        .word
    );

    fetch_buffer #(
        .RVC_ENABLED (RVC_ENABLED),
        .DEPTH       (DEPTH)
    ) u_fetch_buffer (
        .CLK,
        .rst_n,
        .redirect,
        .word_valid,
        .word,
        .insn_ready,
        .free_words,
        .insn_valid,
        .insn
    );

    insn_predecode u_insn_predecode (
        .CLK,
        .rst_n,
        .redirect,
        .insn_valid,
        .insn,
        .out_ready,
        .insn_ready,
        .out_valid,
        .out
    );

endmodule

// ==== tb/frontend_model.svh ====
// reference model for the front end testbench, included inside tb_frontend to predict each output
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

// halfword at a byte address, the image repeats every 1 KB
function automatic logic [15:0] hw_at(input xlen_t a);
    xlen_t w;
    w = mem_img[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
endfunction

// bit 0 with compressed support, either low bit without
function automatic logic target_misaligned(input xlen_t pc);
    return (RVC_ENABLED != 0) ? pc[0] : (pc[1:0] != 2'b00);
endfunction

// major opcode table, compressed flag checked first
function automatic opclass_e class_of(input insn_t i);
    if (i.compressed) return cls_compressed;
    if (i.fault || i.misaligned) return cls_illegal;
    case (i.bits[6:0])
        7'b0000011: return cls_load;
        7'b0100011: return cls_store;
        7'b1100011: return cls_branch;
        7'b1101111: return cls_jal;
        7'b1100111: return cls_jalr;
        7'b0110011: return cls_op;
        7'b0010011: return cls_op_imm;
        7'b0110111: return cls_lui;
        7'b0010111: return cls_auipc;
        7'b1110011: return cls_system;
        7'b0001111: return cls_misc_mem;
        default:    return cls_illegal;
    endcase
endfunction

// expected record for the instruction starting at pc
function automatic decoded_t predict_next(input xlen_t pc, input logic mis);
    decoded_t    d;
    logic [15:0] lo;
    xlen_t       hi_pc;
    d           = '0;
    d.insn.addr = pc;
    lo          = hw_at(pc);
    hi_pc       = pc + 32'd2;
    if (mis) begin
        d.insn.misaligned = 1'b1;  // raw target, no bits
    end else if (err_img[pc[9:2]]) begin
        d.insn.fault = 1'b1;
    end else if ((RVC_ENABLED != 0) && (lo[1:0] != 2'b11)) begin
        d.insn.compressed = 1'b1;
        d.insn.bits       = {16'd0, lo};
    end else if (err_img[hi_pc[9:2]]) begin
        d.insn.fault = 1'b1;  // upper half sits in an error word
    end else begin
        d.insn.bits = {hw_at(hi_pc), lo};
    end
    d.opclass = class_of(d.insn);
    return d;
endfunction

`endif

// ==== tb/tb_frontend.sv ====
// testbench for frontend_top, random program image, redirects and stalls checked against a model
`timescale 1ns/10ps

module tb_frontend
    import rv_frontend_pkg::*;
#(
    parameter int RVC_ENABLED = 1
);

    localparam int unsigned SEED = 32'h8d075b0f;
    localparam int NUM_SEGS   = 150;  // redirects, one stream each
    localparam int MAX_RUN    = 12;   // outputs before a mid-stream redirect
    localparam int WORST_CYC  = 40;   // per instruction, slow memory and heavy stalls
    localparam int TIMEOUT_NS = NUM_SEGS * (MAX_RUN + 8) * WORST_CYC * 10;
    localparam logic [6:0] OPC_LIST [11] = '{7'h03, 7'h23, 7'h63, 7'h6f, 7'h67, 7'h33,
                                             7'h13, 7'h37, 7'h17, 7'h73, 7'h0f};

    logic        CLK;
    logic        rst_n;
    logic        redirect;
    xlen_t       redirect_pc;
    logic        mem_req_valid;
    logic        mem_req_ready;
    mem_req_t    mem_req;
    logic        mem_resp_valid;
    mem_resp_t   mem_resp;
    logic        out_valid;
    logic        out_ready;
    decoded_t    out;

    xlen_t       mem_img [256];  // program image
    logic        err_img [256];  // words that answer with a bus error
    logic [7:0]  pend_idx [$];   // accepted reads, in order
    int unsigned pend_due [$];   // cycle from which each answer may go out
    int unsigned cyc;
    int unsigned stall_pct;      // out_ready low percentage
    xlen_t       exp_pc;         // model pc of the next output
    logic        exp_mis;
    logic        exp_done;       // no output allowed until a redirect
    xlen_t       exp_req;        // next word address the fetch unit should read
    logic        req_open;       // reads allowed after an aligned redirect
    int unsigned seg_outs;

    `include "frontend_model.svh"

    frontend_top #(
        .RVC_ENABLED (RVC_ENABLED),
        .DEPTH       (FETCH_DEPTH)
    ) uut (
        .CLK, .rst_n, .redirect, .redirect_pc,
        .mem_req_valid, .mem_req_ready, .mem_req,
        .mem_resp_valid, .mem_resp,
        .out_valid, .out_ready, .out
    );

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic string check_label(input insn_t i);
        if (i.misaligned) return "misaligned target";
        if (i.fault) return "bus error";
        if (seg_outs == 0) return "redirect target";
        if (stall_pct != 0) return "back-pressure";
        return "straight-line fetch";
    endfunction

    // random target, one in five misaligned
    function automatic xlen_t pick_target();
        xlen_t t;
        t = {22'd0, 10'($urandom_range(1023, 0))};
        if ($urandom_range(4, 0) == 0) begin
            if (RVC_ENABLED != 0) t[0] = 1'b1;
            else t[1:0] = 2'($urandom_range(3, 1));
        end else begin
            t[0] = 1'b0;
            if (RVC_ENABLED == 0) t[1] = 1'b0;  // addr+2 only with rvc
        end
        return t;
    endfunction

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired, the output stream stopped advancing");
        abort_run();
    end

    // memory answers and output stalls, driven on the falling edge
    always @(negedge CLK) begin
        out_ready      = ($urandom_range(99, 0) >= stall_pct);
        mem_req_ready  = ($urandom_range(3, 0) != 0);
        mem_resp_valid = 1'b0;
        if ((pend_due.size() > 0) && (pend_due[0] <= cyc)) begin
            mem_resp_valid = 1'b1;
            mem_resp.data  = mem_img[pend_idx[0]];
            mem_resp.error = err_img[pend_idx[0]];
            pend_idx.delete(0);
            pend_due.delete(0);
        end
    end

    always @(posedge CLK) begin
        decoded_t want;
        cyc = cyc + 1;
        if (rst_n) begin
            if (mem_req_valid && mem_req_ready) begin
                assert (req_open) else begin
                    $display("read request issued while no aligned target is being fetched");
                    abort_run();
                end
                assert (mem_req.addr == exp_req) else begin
                    $display("CHECK FAILED request address: expected %h actual %h",
                             exp_req, mem_req.addr);
                    abort_run();
                end
                exp_req = exp_req + 32'd4;  // sequential word reads
                pend_idx.push_back(mem_req.addr[9:2]);
                pend_due.push_back(cyc + $urandom_range(4, 1));  // 1 to 4 cycles late
            end
            if (out_valid && out_ready) begin
                assert (!exp_done) else begin
                    $display("unexpected output at %h while the stream is stopped",
                             out.insn.addr);
                    abort_run();
                end
                want = predict_next(exp_pc, exp_mis);
                assert (out.insn == want.insn) else begin
                    $display("CHECK FAILED %s: expected %h actual %h",
                             check_label(want.insn), want.insn, out.insn);
                    abort_run();
                end
                assert (out.opclass == want.opclass) else begin
                    $display("CHECK FAILED opcode class: expected %s actual %s",
                             want.opclass.name(), out.opclass.name());
                    abort_run();
                end
                seg_outs = seg_outs + 1;
                exp_mis  = 1'b0;
                exp_done = want.insn.fault || want.insn.misaligned;  // nothing after a fault
                exp_pc   = exp_pc + (want.insn.compressed ? 32'd2 : 32'd4);
            end
            if (redirect) begin
                exp_pc   = redirect_pc;  // old stream dies at this edge
                exp_mis  = target_misaligned(redirect_pc);
                exp_done = 1'b0;
                exp_req  = {redirect_pc[31:2], 2'b00};
                req_open = !target_misaligned(redirect_pc);  // bad target sends no read
                seg_outs = 0;
            end
        end
    end

    initial begin
        int unsigned run_len;
        void'($urandom(SEED));
        rst_n          = 1'b0;
        redirect       = 1'b0;
        redirect_pc    = '0;
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp       = '0;
        out_ready      = 1'b1;
        stall_pct      = 0;
        cyc            = 0;
        exp_pc         = '0;
        exp_mis        = 1'b0;
        exp_done       = 1'b1;  // idle until the first redirect
        exp_req        = '0;
        req_open       = 1'b0;
        seg_outs       = 0;
        for (int i = 0; i < 256; i++) begin
            mem_img[i] = $urandom();
            if ($urandom_range(4, 0) != 0) mem_img[i][6:0] = OPC_LIST[$urandom_range(10, 0)];
            if ((RVC_ENABLED != 0) && ($urandom_range(1, 0) != 0)) begin
                mem_img[i][22:16] = OPC_LIST[$urandom_range(10, 0)];  // full insn in upper half
            end
            err_img[i] = ($urandom_range(23, 0) == 0);
        end
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        for (int seg = 0; seg < NUM_SEGS; seg++) begin
            stall_pct = ((seg % 3) == 0) ? 0 : $urandom_range(60, 10);
            run_len   = $urandom_range(MAX_RUN, 1);
            @(negedge CLK);
            redirect    = 1'b1;
            redirect_pc = pick_target();
            @(negedge CLK);
            redirect = 1'b0;
            while ((seg_outs < run_len) && !exp_done) @(negedge CLK);
            repeat ($urandom_range(6, 0)) @(negedge CLK);  // quiet gap after a fault
        end
        repeat (30) @(negedge CLK);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== rv_frontend.f ====
+incdir+tb
hw/rv_frontend_pkg.sv
hw/fetch_unit.sv
hw/fetch_buffer.sv
hw/insn_predecode.sv
hw/frontend_top.sv
tb/tb_frontend.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        := tb_frontend
RTL_TOP    := frontend_top
FILELIST   := rv_frontend.f
RTL_SRCS   := $(shell grep '^hw/' $(FILELIST))
BUILD_DIR  := build
PASS_MSG   := All tests passed

.PHONY: all run lint clean

all: run

run:
	@for rvc in 0 1; do \
		$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -GRVC_ENABLED=$$rvc \
			--Mdir $(BUILD_DIR)/rvc$$rvc -o sim_$(TOP) || exit 1; \
		$(BUILD_DIR)/rvc$$rvc/sim_$(TOP) > sim_rvc$$rvc.log 2>&1; \
		grep -q "$(PASS_MSG)" sim_rvc$$rvc.log || { echo "RVC_ENABLED=$$rvc FAILED"; exit 1; }; \
		echo "RVC_ENABLED=$$rvc passed"; \
	done

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) sim_rvc*.log
